//--- issue_stage.f
+incdir+include
hdl/issue_instr_pkg.sv
hdl/issue_csr_pkg.sv
hdl/scoreboard.sv
hdl/register_file.sv
hdl/operand_select.sv
hdl/status_counters.sv
hdl/issue_stage.sv
bench/issue_stage_tb.sv

//--- Bender.yml
package:
  name: issue_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/issue_instr_pkg.sv
      - hdl/issue_csr_pkg.sv
      - hdl/scoreboard.sv
      - hdl/register_file.sv
      - hdl/operand_select.sv
      - hdl/status_counters.sv
      - hdl/issue_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/issue_stage_tb.sv

//--- bench/issue_stage_tb.sv
// Issue stage testbench

`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_stage_tb
	import issue_instr_pkg::*;
();

	localparam int         ISSUE_TIMEOUT = 20;
	localparam logic [1:0] KIND_EXACT    = 2'd0;
	localparam logic [1:0] KIND_MARK     = 2'd1;
	localparam logic [1:0] KIND_DELTA    = 2'd2;
	localparam logic [1:0] KIND_INSTRET  = 2'd3;

	// One table row: inputs for a cycle and what the stage should answer
	typedef struct packed {
		logic                         valid;
		preg_t                        dst;
		preg_t                        src1;
		preg_t                        src2;
		logic                         src1_pc;
		logic                         src2_imm;
		fu_t                          fu;
		uop_t                         uop;
		data_t                        imm;
		data_t                        pc;
		ticket_t                      ticket;
		logic                         res_valid;
		fu_t                          res_fu;
		preg_t                        res_dst;
		ticket_t                      res_ticket;
		data_t                        res_data;
		logic [`ISSUE_FU_COUNT-1:0]   busy;
		logic                         wb_commit;
		logic                         wb_write;
		logic                         wb_flushed;
		preg_t                        wb_dst;
		ticket_t                      wb_ticket;
		data_t                        wb_data;
		logic                         flush_valid;
		logic [`ISSUE_ROB_SIZE-1:0]   flush_keep;
		data_t                        rob0;
		data_t                        rob1;
		logic                         exp_issue;
		data_t                        exp_d1;
		data_t                        exp_d2;
		logic [1:0]                   kind;
		logic                         rob_chk;
		ticket_t                      exp_rob;
	} step_t;

	logic clk;
	logic rst_n;
	logic instr_valid;
	preg_t instr_dst;
	preg_t instr_src1;
	preg_t instr_src2;
	logic instr_src1_pc;
	logic instr_src2_imm;
	fu_t instr_fu;
	uop_t instr_uop;
	data_t instr_imm;
	data_t instr_pc;
	ticket_t instr_ticket;
	logic issue;
	logic ex_valid;
	preg_t ex_dst;
	ticket_t ex_ticket;
	fu_t ex_fu;
	uop_t ex_uop;
	data_t ex_data1;
	data_t ex_data2;
	logic [`ISSUE_FU_COUNT-1:0] fu_result_valid;
	preg_t [`ISSUE_FU_COUNT-1:0] fu_result_dst;
	ticket_t [`ISSUE_FU_COUNT-1:0] fu_result_ticket;
	data_t [`ISSUE_FU_COUNT-1:0] fu_result_data;
	logic [`ISSUE_FU_COUNT-1:0] busy_fu;
	ticket_t [1:0] rob_addr;
	data_t [1:0] rob_data;
	logic wb_commit;
	logic wb_write;
	logic wb_flushed;
	preg_t wb_dst;
	ticket_t wb_ticket;
	data_t wb_data;
	logic flush_valid;
	logic [`ISSUE_ROB_SIZE-1:0] flush_keep;

	step_t  steps [0:31];
	int     num_steps;
	int     errors;
	int     checks;
	int     commits;
	int     mark_step;
	data_t  mark_value;
	integer seed;
	logic   timed_out;

	issue_stage dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Table helpers
	// ----------------------------------------------------------------------
	function automatic step_t blank_step();
		step_t s;
		s = '0;
		s.fu = fu_integer;
		s.flush_keep = '1;
		return s;
	endfunction

	function automatic step_t new_instr(input preg_t dst, input preg_t src1, input preg_t src2,
		input fu_t fu, input ticket_t ticket, input logic exp_issue,
		input data_t exp_d1, input data_t exp_d2);
		step_t s;
		s = blank_step();
		s.valid = 1'b1;
		s.dst = dst;
		s.src1 = src1;
		s.src2 = src2;
		s.fu = fu;
		s.uop = 5'd1;
		s.ticket = ticket;
		s.exp_issue = exp_issue;
		s.exp_d1 = exp_d1;
		s.exp_d2 = exp_d2;
		return s;
	endfunction

	task automatic add_step(input step_t s);
		steps[num_steps] = s;
		num_steps++;
	endtask

	task automatic build_table();
		step_t s;
		data_t r1;
		data_t r2;
		data_t r3;
		data_t r4;
		data_t r5;
		data_t pc_val;
		data_t imm_val;
		seed = 43245;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		r4 = $random(seed);
		r5 = $random(seed);
		pc_val = $random(seed);
		imm_val = $random(seed);
		num_steps = 0;
		// Free sources read zero, commit r5 in the same cycle
		s = new_instr(0, 3, 4, fu_integer, 0, 1'b1, 32'd0, 32'd0);
		s.wb_commit = 1'b1;
		s.wb_write = 1'b1;
		s.wb_dst = 5;
		s.wb_data = r1;
		add_step(s);
		add_step(new_instr(0, 5, 0, fu_integer, 1, 1'b1, r1, 32'd0));
		// Writer of r7 on the float unit, then a reader that must wait
		add_step(new_instr(7, 5, 0, fu_float, 2, 1'b1, r1, 32'd0));
		s = new_instr(8, 7, 5, fu_integer, 3, 1'b0, 32'd0, 32'd0);
		s.res_valid = 1'b1;
		s.res_fu = fu_integer;
		s.res_dst = 7;
		s.res_ticket = 1;
		s.res_data = r4;
		add_step(s);
		s.res_valid = 1'b0;
		add_step(s);
		s.res_valid = 1'b1;
		s.res_fu = fu_float;
		s.res_ticket = 2;
		s.res_data = r2;
		s.exp_issue = 1'b1;
		s.exp_d1 = r2;
		s.exp_d2 = r1;
		add_step(s);
		// r7 now lives in the ROB under ticket 2
		s = new_instr(0, 7, 7, fu_integer, 4, 1'b1, r4, r3);
		s.rob0 = r4;
		s.rob1 = r3;
		s.rob_chk = 1'b1;
		s.exp_rob = 2;
		add_step(s);
		// Second writer of r7 blocked by WAW until the right commit
		s = new_instr(7, 0, 0, fu_integer, 4, 1'b0, 32'd0, imm_val);
		s.src2_imm = 1'b1;
		s.imm = imm_val;
		s.wb_commit = 1'b1;
		s.wb_write = 1'b1;
		s.wb_dst = 7;
		s.wb_ticket = 5;
		s.wb_data = r4;
		add_step(s);
		s.wb_commit = 1'b0;
		s.wb_write = 1'b0;
		add_step(s);
		s.wb_commit = 1'b1;
		s.wb_write = 1'b1;
		s.wb_ticket = 2;
		s.wb_data = r5;
		add_step(s);
		s.wb_commit = 1'b0;
		s.wb_write = 1'b0;
		s.busy[fu_integer] = 1'b1;
		add_step(s);
		s.busy = '0;
		s.exp_issue = 1'b1;
		add_step(s);
		// Flush drops ticket 4, reader falls back to the register file
		s = new_instr(0, 7, 0, fu_integer, 5, 1'b0, 32'd0, 32'd0);
		s.flush_valid = 1'b1;
		s.flush_keep = 8'hEF;
		add_step(s);
		s.flush_valid = 1'b0;
		s.flush_keep = '1;
		s.exp_issue = 1'b1;
		s.exp_d1 = r5;
		add_step(s);
		// Counter reads with PC and immediate operands in between
		s = new_instr(0, 0, 0, fu_integer, 6, 1'b1, 32'd0, `ISSUE_IMM_CYCLE);
		s.uop = 5'd0;
		s.src2_imm = 1'b1;
		s.imm = `ISSUE_IMM_CYCLE;
		s.kind = KIND_MARK;
		add_step(s);
		s.kind = KIND_DELTA;
		steps[num_steps + 2] = s;
		s = new_instr(0, 0, 0, fu_branch, 7, 1'b1, pc_val, imm_val);
		s.src1_pc = 1'b1;
		s.pc = pc_val;
		s.src2_imm = 1'b1;
		s.imm = imm_val;
		s.wb_commit = 1'b1;
		s.wb_flushed = 1'b1;
		add_step(s);
		s = blank_step();
		s.wb_commit = 1'b1;
		add_step(s);
		num_steps++;
		s = new_instr(0, 0, 0, fu_integer, 0, 1'b1, 32'd0, `ISSUE_IMM_INSTRET);
		s.uop = 5'd0;
		s.src2_imm = 1'b1;
		s.imm = `ISSUE_IMM_INSTRET;
		s.kind = KIND_INSTRET;
		add_step(s);
		s.imm = `ISSUE_IMM_INSTRETH;
		s.exp_d2 = `ISSUE_IMM_INSTRETH;
		s.kind = KIND_EXACT;
		add_step(s);
	endtask

	// ----------------------------------------------------------------------
	// Drive and check
	// ----------------------------------------------------------------------
	task automatic drive_step(input step_t s);
		instr_valid = s.valid;
		instr_dst = s.dst;
		instr_src1 = s.src1;
		instr_src2 = s.src2;
		instr_src1_pc = s.src1_pc;
		instr_src2_imm = s.src2_imm;
		instr_fu = s.fu;
		instr_uop = s.uop;
		instr_imm = s.imm;
		instr_pc = s.pc;
		instr_ticket = s.ticket;
		fu_result_valid = '0;
		fu_result_dst = '0;
		fu_result_ticket = '0;
		fu_result_data = '0;
		if (s.res_valid) begin
			fu_result_valid[s.res_fu] = 1'b1;
			fu_result_dst[s.res_fu] = s.res_dst;
			fu_result_ticket[s.res_fu] = s.res_ticket;
			fu_result_data[s.res_fu] = s.res_data;
		end
		busy_fu = s.busy;
		rob_data[0] = s.rob0;
		rob_data[1] = s.rob1;
		wb_commit = s.wb_commit;
		wb_write = s.wb_write;
		wb_flushed = s.wb_flushed;
		wb_dst = s.wb_dst;
		wb_ticket = s.wb_ticket;
		wb_data = s.wb_data;
		flush_valid = s.flush_valid;
		flush_keep = s.flush_keep;
	endtask

	task automatic report_mismatch(input int k, input string what, input data_t got,
		input data_t exp);
		$display("MISMATCH at %0t: step %0d %s got %h expected %h", $time, k, what, got, exp);
		errors++;
	endtask

	// Inputs stay held while polling, so a late issue still sees the same instruction
	task automatic wait_for_issue(input int k, output logic expired);
		int waited;
		waited = 0;
		expired = 1'b0;
		if (issue !== 1'b1) begin
			report_mismatch(k, "issue", issue, 1'b1);
		end
		while (issue !== 1'b1 && waited < ISSUE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (issue !== 1'b1) begin
			$display("Timeout: issue stayed low for %0d cycles at step %0d", waited, k);
			errors++;
			expired = 1'b1;
		end
	endtask

	task automatic check_step(input int k, input step_t s);
		data_t exp1;
		exp1 = s.exp_d1;
		checks++;
		if (issue !== s.exp_issue) begin
			report_mismatch(k, "issue", issue, s.exp_issue);
		end
		if (ex_valid !== s.exp_issue) begin
			report_mismatch(k, "ex_valid", ex_valid, s.exp_issue);
		end
		if (s.exp_issue) begin
			case (s.kind)
				KIND_MARK: begin
					mark_step = k;
					mark_value = ex_data1;
				end
				KIND_DELTA: exp1 = mark_value + data_t'(k - mark_step);
				KIND_INSTRET: exp1 = data_t'(commits);
				default: exp1 = s.exp_d1;
			endcase
			if (s.kind != KIND_MARK && ex_data1 !== exp1) begin
				report_mismatch(k, "ex_data1", ex_data1, exp1);
			end
			if (ex_data2 !== s.exp_d2) begin
				report_mismatch(k, "ex_data2", ex_data2, s.exp_d2);
			end
			if (ex_dst !== s.dst) begin
				report_mismatch(k, "ex_dst", ex_dst, s.dst);
			end
			if (ex_ticket !== s.ticket) begin
				report_mismatch(k, "ex_ticket", ex_ticket, s.ticket);
			end
			if (ex_fu !== s.fu) begin
				report_mismatch(k, "ex_fu", ex_fu, s.fu);
			end
			if (ex_uop !== s.uop) begin
				report_mismatch(k, "ex_uop", ex_uop, s.uop);
			end
		end
		if (s.rob_chk && rob_addr[0] !== s.exp_rob) begin
			report_mismatch(k, "rob_addr[0]", rob_addr[0], s.exp_rob);
		end
		if (s.rob_chk && rob_addr[1] !== s.exp_rob) begin
			report_mismatch(k, "rob_addr[1]", rob_addr[1], s.exp_rob);
		end
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial begin
		errors = 0;
		checks = 0;
		commits = 0;
		mark_step = 0;
		mark_value = '0;
		timed_out = 1'b0;
		rst_n = 1'b0;
		drive_step(blank_step());
		build_table();
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		for (int k = 0; k < num_steps; k++) begin
			@(posedge clk);
			#1 drive_step(steps[k]);
			@(negedge clk);
			if (steps[k].exp_issue) begin
				wait_for_issue(k, timed_out);
			end
			if (timed_out) begin
				break;
			end
			check_step(k, steps[k]);
			// Commit takes effect at the next edge
			if (steps[k].wb_commit && !steps[k].wb_flushed) begin
				commits++;
			end
		end
		@(posedge clk);
		#1 drive_step(blank_step());
		$display("Checked %0d steps, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/issue_stage.sv
// Single-lane issue stage

`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_stage
	import issue_instr_pkg::*;
	import issue_csr_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst_n,
	// Renamed instruction
	input  logic                              instr_valid,
	input  preg_t                             instr_dst,
	input  preg_t                             instr_src1,
	input  preg_t                             instr_src2,
	input  logic                              instr_src1_pc,
	input  logic                              instr_src2_imm,
	input  fu_t                               instr_fu,
	input  uop_t                              instr_uop,
	input  data_t                             instr_imm,
	input  data_t                             instr_pc,
	input  ticket_t                           instr_ticket,
	output logic                              issue,
	// Towards execute
	output logic                              ex_valid,
	output preg_t                             ex_dst,
	output ticket_t                           ex_ticket,
	output fu_t                               ex_fu,
	output uop_t                              ex_uop,
	output data_t                             ex_data1,
	output data_t                             ex_data2,
	// FU results and busy flags
	input  logic    [`ISSUE_FU_COUNT-1:0]     fu_result_valid,
	input  preg_t   [`ISSUE_FU_COUNT-1:0]     fu_result_dst,
	input  ticket_t [`ISSUE_FU_COUNT-1:0]     fu_result_ticket,
	input  data_t   [`ISSUE_FU_COUNT-1:0]     fu_result_data,
	input  logic    [`ISSUE_FU_COUNT-1:0]     busy_fu,
	// ROB read port
	output ticket_t [1:0]                     rob_addr,
	input  data_t   [1:0]                     rob_data,
	// Commit and flush from the ROB
	input  logic                              wb_commit,
	input  logic                              wb_write,
	input  logic                              wb_flushed,
	input  preg_t                             wb_dst,
	input  ticket_t                           wb_ticket,
	input  data_t                             wb_data,
	input  logic                              flush_valid,
	input  logic    [`ISSUE_ROB_SIZE-1:0]     flush_keep
);

	logic     dst_pending;
	logic     src1_pending;
	logic     src2_pending;
	logic     src1_in_rob;
	logic     src2_in_rob;
	fu_t      src1_fu;
	fu_t      src2_fu;
	data_t    rf_data1;
	data_t    rf_data2;
	data_t    counter_value;
	csr_sel_t csr_sel;

	// Fields passed on to execute unchanged
	assign ex_valid  = issue;
	assign ex_dst    = instr_dst;
	assign ex_ticket = instr_ticket;
	assign ex_fu     = instr_fu;
	assign ex_uop    = instr_uop;

	scoreboard u_scoreboard (
		.clk              (clk),
		.rst_n            (rst_n),
		.issue            (issue),
		.instr_dst        (instr_dst),
		.instr_ticket     (instr_ticket),
		.instr_fu         (instr_fu),
		.instr_src1       (instr_src1),
		.instr_src2       (instr_src2),
		.fu_result_valid  (fu_result_valid),
		.fu_result_dst    (fu_result_dst),
		.fu_result_ticket (fu_result_ticket),
		.wb_commit        (wb_commit),
		.wb_write         (wb_write),
		.wb_dst           (wb_dst),
		.wb_ticket        (wb_ticket),
		.flush_valid      (flush_valid),
		.flush_keep       (flush_keep),
		.dst_pending      (dst_pending),
		.src1_pending     (src1_pending),
		.src2_pending     (src2_pending),
		.src1_in_rob      (src1_in_rob),
		.src2_in_rob      (src2_in_rob),
		.src1_fu          (src1_fu),
		.src2_fu          (src2_fu),
		.rob_addr         (rob_addr)
	);

	register_file u_register_file (
		.clk        (clk),
		.rst_n      (rst_n),
		.write_en   (wb_commit & wb_write),
		.write_addr (wb_dst),
		.write_data (wb_data),
		.read_addr1 (instr_src1),
		.read_addr2 (instr_src2),
		.read_data1 (rf_data1),
		.read_data2 (rf_data2)
	);

	operand_select u_operand_select (
		.instr_valid     (instr_valid),
		.instr_src1      (instr_src1),
		.instr_src2      (instr_src2),
		.instr_src1_pc   (instr_src1_pc),
		.instr_src2_imm  (instr_src2_imm),
		.instr_fu        (instr_fu),
		.instr_uop       (instr_uop),
		.instr_imm       (instr_imm),
		.instr_pc        (instr_pc),
		.busy_fu         (busy_fu),
		.dst_pending     (dst_pending),
		.src1_pending    (src1_pending),
		.src2_pending    (src2_pending),
		.src1_in_rob     (src1_in_rob),
		.src2_in_rob     (src2_in_rob),
		.src1_fu         (src1_fu),
		.src2_fu         (src2_fu),
		.fu_result_valid (fu_result_valid),
		.fu_result_dst   (fu_result_dst),
		.fu_result_data  (fu_result_data),
		.rob_data        (rob_data),
		.rf_data1        (rf_data1),
		.rf_data2        (rf_data2),
		.counter_value   (counter_value),
		.issue           (issue),
		.csr_sel         (csr_sel),
		.ex_data1        (ex_data1),
		.ex_data2        (ex_data2)
	);

	status_counters u_status_counters (
		.clk           (clk),
		.rst_n         (rst_n),
		.retire        (wb_commit & ~wb_flushed),
		.csr_sel       (csr_sel),
		.counter_value (counter_value)
	);

endmodule

`default_nettype wire

//--- hdl/status_counters.sv
// Cycle and retired-instruction counters

`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module status_counters
	import issue_instr_pkg::*;
	import issue_csr_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     retire,
	input  csr_sel_t csr_sel,
	output data_t    counter_value
);

	counter_t cycle_count;
	counter_t instret_count;

	// Free-running cycle count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle_count <= '0;
		end else begin
			cycle_count <= cycle_count + 64'd1;
		end
	end

	// Non-flushed commits only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instret_count <= '0;
		end else if (retire) begin
			instret_count <= instret_count + 64'd1;
		end
	end

	// Half select for the counter read
	always_comb begin
		case (csr_sel)
			csr_cycle:    counter_value = cycle_count[31:0];
			csr_cycleh:   counter_value = cycle_count[63:32];
			csr_instret:  counter_value = instret_count[31:0];
			csr_instreth: counter_value = instret_count[63:32];
			default:      counter_value = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/operand_select.sv
// Operand sourcing and issue decision

`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module operand_select
	import issue_instr_pkg::*;
	import issue_csr_pkg::*;
(
	input  logic                        instr_valid,
	input  preg_t                       instr_src1,
	input  preg_t                       instr_src2,
	input  logic                        instr_src1_pc,
	input  logic                        instr_src2_imm,
	input  fu_t                         instr_fu,
	input  uop_t                        instr_uop,
	input  data_t                       instr_imm,
	input  data_t                       instr_pc,
	input  logic  [`ISSUE_FU_COUNT-1:0] busy_fu,
	input  logic                        dst_pending,
	input  logic                        src1_pending,
	input  logic                        src2_pending,
	input  logic                        src1_in_rob,
	input  logic                        src2_in_rob,
	input  fu_t                         src1_fu,
	input  fu_t                         src2_fu,
	input  logic  [`ISSUE_FU_COUNT-1:0] fu_result_valid,
	input  preg_t [`ISSUE_FU_COUNT-1:0] fu_result_dst,
	input  data_t [`ISSUE_FU_COUNT-1:0] fu_result_data,
	input  data_t [1:0]                 rob_data,
	input  data_t                       rf_data1,
	input  data_t                       rf_data2,
	input  data_t                       counter_value,
	output logic                        issue,
	output csr_sel_t                    csr_sel,
	output data_t                       ex_data1,
	output data_t                       ex_data2
);

	logic counter_form;
	logic src1_ok;
	logic src2_ok;
	logic src1_fwd;
	logic src2_fwd;

	// ----------------------------------------------------------------------
	// Counter read decode
	// ----------------------------------------------------------------------
	assign counter_form = (instr_fu == fu_integer) && (instr_uop == '0)
		&& (instr_src1 == '0) && (instr_src2 == '0);

	always_comb begin
		csr_sel = csr_none;
		if (counter_form) begin
			if (instr_imm == `ISSUE_IMM_CYCLE) begin
				csr_sel = csr_cycle;
			end else if (instr_imm == `ISSUE_IMM_CYCLEH) begin
				csr_sel = csr_cycleh;
			end else if (instr_imm == `ISSUE_IMM_INSTRET) begin
				csr_sel = csr_instret;
			end else if (instr_imm == `ISSUE_IMM_INSTRETH) begin
				csr_sel = csr_instreth;
			end
		end
	end

	// Producer FU is writing the source right now
	assign src1_fwd = fu_result_valid[src1_fu] && (fu_result_dst[src1_fu] == instr_src1);
	assign src2_fwd = fu_result_valid[src2_fu] && (fu_result_dst[src2_fu] == instr_src2);

	// Source 1: PC, counter, ROB, FU result, then register file
	always_comb begin
		src1_ok  = 1'b1;
		ex_data1 = rf_data1;
		if (instr_src1_pc) begin
			ex_data1 = instr_pc;
		end else if (csr_sel != csr_none) begin
			ex_data1 = counter_value;
		end else if (src1_pending) begin
			if (src1_in_rob) begin
				ex_data1 = rob_data[0];
			end else if (src1_fwd) begin
				ex_data1 = fu_result_data[src1_fu];
			end else begin
				src1_ok = 1'b0;
			end
		end
	end

	// Source 2: immediate, ROB, FU result, then register file
	always_comb begin
		src2_ok  = 1'b1;
		ex_data2 = rf_data2;
		if (instr_src2_imm) begin
			ex_data2 = instr_imm;
		end else if (src2_pending) begin
			if (src2_in_rob) begin
				ex_data2 = rob_data[1];
			end else if (src2_fwd) begin
				ex_data2 = fu_result_data[src2_fu];
			end else begin
				src2_ok = 1'b0;
			end
		end
	end

	// WAW, structural and RAW checks
	assign issue = instr_valid & ~busy_fu[instr_fu] & ~dst_pending & src1_ok & src2_ok;

endmodule

`default_nettype wire

//--- hdl/register_file.sv
// Physical register file

`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module register_file
	import issue_instr_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  write_en,
	input  preg_t write_addr,
	input  data_t write_data,
	input  preg_t read_addr1,
	input  preg_t read_addr2,
	output data_t read_data1,
	output data_t read_data2
);

	data_t mem [`ISSUE_PREGS];

	// Committed values, x0 is hardwired to zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `ISSUE_PREGS; i++) begin
				mem[i] <= '0;
			end
		end else if (write_en && (write_addr != '0)) begin
			mem[write_addr] <= write_data;
		end
	end

	// Asynchronous reads, no write bypass
	assign read_data1 = mem[read_addr1];
	assign read_data2 = mem[read_addr2];

endmodule

`default_nettype wire

//--- hdl/scoreboard.sv
// Physical register scoreboard

`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module scoreboard
	import issue_instr_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          issue,
	input  preg_t                         instr_dst,
	input  ticket_t                       instr_ticket,
	input  fu_t                           instr_fu,
	input  preg_t                         instr_src1,
	input  preg_t                         instr_src2,
	input  logic    [`ISSUE_FU_COUNT-1:0] fu_result_valid,
	input  preg_t   [`ISSUE_FU_COUNT-1:0] fu_result_dst,
	input  ticket_t [`ISSUE_FU_COUNT-1:0] fu_result_ticket,
	input  logic                          wb_commit,
	input  logic                          wb_write,
	input  preg_t                         wb_dst,
	input  ticket_t                       wb_ticket,
	input  logic                          flush_valid,
	input  logic    [`ISSUE_ROB_SIZE-1:0] flush_keep,
	output logic                          dst_pending,
	output logic                          src1_pending,
	output logic                          src2_pending,
	output logic                          src1_in_rob,
	output logic                          src2_in_rob,
	output fu_t                           src1_fu,
	output fu_t                           src2_fu,
	output ticket_t [1:0]                 rob_addr
);

	// Per-register state
	logic [`ISSUE_PREGS-1:0] pending;
	logic [`ISSUE_PREGS-1:0] in_rob;
	ticket_t                 ticket [`ISSUE_PREGS];
	fu_t                     fu [`ISSUE_PREGS];

	logic [`ISSUE_PREGS-1:0]    issue_hit;
	logic [`ISSUE_PREGS-1:0]    wb_hit;
	logic [`ISSUE_PREGS-1:0]    flush_hit;
	logic [`ISSUE_PREGS-1:0]    result_hit;
	logic [`ISSUE_FU_COUNT-1:0] result_ok;
	logic                       wb_match;

	// Lookups for the instruction at the head
	assign dst_pending  = pending[instr_dst];
	assign src1_pending = pending[instr_src1];
	assign src2_pending = pending[instr_src2];
	assign src1_in_rob  = in_rob[instr_src1];
	assign src2_in_rob  = in_rob[instr_src2];
	assign src1_fu      = fu[instr_src1];
	assign src2_fu      = fu[instr_src2];
	assign rob_addr[0]  = ticket[instr_src1];
	assign rob_addr[1]  = ticket[instr_src2];

	// Only the youngest writer of a register may release it
	assign wb_match = wb_commit & wb_write & (wb_ticket == ticket[wb_dst]);

	// A result is dropped when a new writer of the same register issues now
	always_comb begin
		for (int j = 0; j < `ISSUE_FU_COUNT; j++) begin
			result_ok[j] = fu_result_valid[j]
				&& (fu_result_ticket[j] == ticket[fu_result_dst[j]])
				&& !(issue && (instr_dst == fu_result_dst[j]));
		end
	end

	// ----------------------------------------------------------------------
	// Per-entry event decode
	// ----------------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < `ISSUE_PREGS; i++) begin
			issue_hit[i]  = issue && (instr_dst == preg_t'(i));
			wb_hit[i]     = wb_match && (wb_dst == preg_t'(i));
			flush_hit[i]  = flush_valid && !flush_keep[ticket[i]];
			result_hit[i] = 1'b0;
			for (int j = 0; j < `ISSUE_FU_COUNT; j++) begin
				if (result_ok[j] && (fu_result_dst[j] == preg_t'(i))) begin
					result_hit[i] = 1'b1;
				end
			end
		end
	end

	// Flush beats issue, issue beats writeback; x0 stays free
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
			in_rob  <= '0;
		end else begin
			pending[0] <= 1'b0;
			in_rob[0]  <= 1'b0;
			for (int i = 1; i < `ISSUE_PREGS; i++) begin
				if (flush_hit[i]) begin
					pending[i] <= 1'b0;
				end else if (issue_hit[i]) begin
					pending[i] <= 1'b1;
				end else if (wb_hit[i]) begin
					pending[i] <= 1'b0;
				end
				if (issue_hit[i]) begin
					in_rob[i] <= 1'b0;
				end else if (result_hit[i]) begin
					in_rob[i] <= 1'b1;
				end
			end
		end
	end

	// Producer tag of the latest writer
	always_ff @(posedge clk) begin
		for (int i = 0; i < `ISSUE_PREGS; i++) begin
			if (issue_hit[i]) begin
				ticket[i] <= instr_ticket;
				fu[i]     <= instr_fu;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/issue_csr_pkg.sv
// Machine counter types

`default_nettype none

`include "issue_config.svh"

package issue_csr_pkg;

	// Which counter half a read returns
	typedef enum logic [2:0] {
		csr_none    = 3'd0,
		csr_cycle   = 3'd1,
		csr_cycleh  = 3'd2,
		csr_instret = 3'd3,
		csr_instreth = 3'd4
	} csr_sel_t;

	typedef logic [63:0] counter_t;

endpackage

`default_nettype wire

//--- hdl/issue_instr_pkg.sv
// Instruction field types

`default_nettype none

`include "issue_config.svh"

package issue_instr_pkg;

	// Register, ROB and datapath fields
	typedef logic [`ISSUE_PREG_BITS-1:0]   preg_t;
	typedef logic [`ISSUE_TICKET_BITS-1:0] ticket_t;
	typedef logic [`ISSUE_DATA_WIDTH-1:0]  data_t;
	typedef logic [`ISSUE_UOP_BITS-1:0]    uop_t;

	// Functional unit codes, also used as index of the result arrays
	typedef enum logic [1:0] {
		fu_load_store = 2'b00,
		fu_float      = 2'b01,
		fu_integer    = 2'b10,
		fu_branch     = 2'b11
	} fu_t;

endpackage

`default_nettype wire

//--- include/issue_config.svh
// Issue stage sizes and counter-read encodings

`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Datapath and storage sizes
`define ISSUE_DATA_WIDTH  32
`define ISSUE_PREGS       64
`define ISSUE_PREG_BITS   6
`define ISSUE_TICKET_BITS 3
`define ISSUE_ROB_SIZE    8
`define ISSUE_FU_COUNT    4
`define ISSUE_UOP_BITS    5

// ----------------------------------------------------------------------
// Immediates that turn an integer add of x0 into a counter read
// ----------------------------------------------------------------------
`define ISSUE_IMM_CYCLE    (-1024)
`define ISSUE_IMM_CYCLEH   (-896)
`define ISSUE_IMM_INSTRET  (-1022)
`define ISSUE_IMM_INSTRETH (-894)

`endif
